/* vlog.f */
design/sp_pixel_pkg.sv
design/sp_ctrl_pkg.sv
design/column_counter.sv
design/window_fsm.sv
design/window_buffer.sv
design/direction_calc.sv
design/noise_decision.sv
design/sp_noise_removal.sv
verification/tb_sp_noise_removal.sv

/* Makefile */
# Verilator build, run, lint and clean

TOP = tb_sp_noise_removal

.PHONY: all run lint clean

all: run

obj_dir/V$(TOP): vlog.f $(wildcard design/*.sv) $(wildcard verification/*.sv)
	verilator --binary --timing --assert -f vlog.f --top-module $(TOP)

run: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) 2>&1 | tee sim.log
	@! grep -q "Test failed" sim.log
	@grep -q "Test completed successfully" sim.log

lint:
	verilator --lint-only -Wall --timing -f vlog.f --top-module $(TOP)

clean:
	rm -rf obj_dir sim.log

/* verification/tb_sp_noise_removal.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_sp_noise_removal
    import sp_pixel_pkg::*;
();

    localparam int SIGMA     = 160;
    localparam int LAT       = 5;                   // drive edge to checked output
    localparam int THRESH    = SIGMA * QUANT / 16;  // 680
    localparam int N_ENT     = 13;
    localparam int DRAIN_MAX = 4 * LAT;

    localparam int K_FLAT   = 0;
    localparam int K_RAMP   = 1;
    localparam int K_RAND   = 2;
    localparam int K_COARSE = 3;  // four grey levels, lots of gradient ties

    // (row, col) of outer pair then inner pair, for H, V, 45 and 135 degrees
    localparam int TAPS [4][8] = '{
        '{2, 0, 2, 4, 2, 1, 2, 3},
        '{0, 2, 4, 2, 1, 2, 3, 2},
        '{0, 0, 4, 4, 1, 1, 3, 3},
        '{0, 4, 4, 0, 1, 3, 3, 1}
    };

    typedef struct {
        int len;
        int kind;
        int base;
        int inj_r;     // -1 when nothing is injected
        int inj_c;
        int inj_v;
        int border_c;  // -1 when no border column
        int gap;
    } entry_t;

    logic    clk;
    logic    rst_n;
    logic    en_i;
    column_t col_i;
    logic    border_pass_i;
    pixel_t  data_o;
    logic    en_o;

    integer seed = 16;

    entry_t tbl [N_ENT];
    int     win_m [WIN_N][WIN_N];  // [column][row], column 0 newest
    int     run_len;
    bit     exp_en_q [$];
    int     exp_data_q [$];
    int     exp_tag_q [$];
    int     report_idx;
    int     checks;
    int     errors;
    int     ent_slots [N_ENT];
    int     ent_hits [N_ENT];
    int     ent_errors [N_ENT];

    sp_noise_removal #(
        .SIGMA (SIGMA)
    ) i_sp_noise_removal (
        .clk           (clk),
        .rst_n         (rst_n),
        .en_i          (en_i),
        .col_i         (col_i),
        .border_pass_i (border_pass_i),
        .data_o        (data_o),
        .en_o          (en_o)
    );

    always #4 clk = ~clk;

    function automatic int abs_val(input int v);
        return (v < 0) ? -v : v;
    endfunction

    function automatic int half_up(input int a, input int b);
        return (a + b + 1) / 2;
    endfunction

    function automatic int pix_at(input int r, input int c);
        return win_m[c][r];
    endfunction

    // expected output for the window now held in win_m
    function automatic int predict(input bit border);
        int oa;
        int ob;
        int ia;
        int ib;
        int grad;
        int intp;
        int best_g;
        int best_i;
        int ctr;
        best_g = 0;
        best_i = 0;
        ctr    = pix_at(WIN_MID, WIN_MID);
        for (int d = 0; d < 4; d++) begin
            oa   = pix_at(TAPS[d][0], TAPS[d][1]);
            ob   = pix_at(TAPS[d][2], TAPS[d][3]);
            ia   = pix_at(TAPS[d][4], TAPS[d][5]);
            ib   = pix_at(TAPS[d][6], TAPS[d][7]);
            grad = abs_val(oa - ob) + abs_val(ia - ib);
            intp = half_up(half_up(oa, ob), half_up(ia, ib));
            if (d == 0 || grad < best_g) begin  // earlier direction keeps a tie
                best_g = grad;
                best_i = intp;
            end
        end
        if (best_i > PIX_MAX) begin
            best_i = PIX_MAX;
        end
        if (border) begin
            return ctr;
        end
        if ((ctr == 0 || ctr == PIX_MAX) && abs_val(ctr - best_i) > THRESH) begin
            return best_i;
        end
        return ctr;
    endfunction

    function automatic int gen_pixel(input int kind, input int base, input int r, input int c);
        int v;
        case (kind)
            K_FLAT: v = base;
            K_RAMP: v = base + 23 * c + 41 * r;
            default: begin
                if ({$random(seed)} % 10 == 0) begin
                    v = ({$random(seed)} % 2 == 0) ? 0 : PIX_MAX;  // pepper or salt
                end else if (kind == K_COARSE) begin
                    v = 512 + 1024 * int'({$random(seed)} % 4);
                end else begin
                    v = int'({$random(seed)} % 4096);
                end
            end
        endcase
        return v;
    endfunction

    function automatic string kind_name(input int kind);
        case (kind)
            K_FLAT:  return "flat";
            K_RAMP:  return "ramp";
            K_RAND:  return "random";
            default: return "coarse";
        endcase
    endfunction

    task automatic report_entry(input int idx);
        if (idx >= 0 && idx < N_ENT) begin
            $display("entry %0d, %s row of %0d: %0d slots, %0d results, %0d mismatches",
                     idx, kind_name(tbl[idx].kind), tbl[idx].len,
                     ent_slots[idx], ent_hits[idx], ent_errors[idx]);
        end
    endtask

    // check the slot due now, then drive the next column and predict it
    task automatic step(input bit en, input int col_v [WIN_N], input bit border, input int tag);
        bit want_en;
        int want_data;
        int want_tag;
        int fails;
        @(negedge clk);
        want_en   = exp_en_q.pop_front();
        want_data = exp_data_q.pop_front();
        want_tag  = exp_tag_q.pop_front();
        fails     = 0;
        if (want_tag != report_idx) begin
            report_entry(report_idx);
            report_idx = want_tag;
        end
        checks++;
        if (en_o !== want_en) begin
            fails++;
            $display("Mismatch at %0t: en_o %b, expected %b (entry %0d)",
                     $time, en_o, want_en, want_tag);
        end
        if (data_o !== pixel_t'(want_data)) begin
            fails++;
            $display("Mismatch at %0t: data_o %0d, expected %0d (entry %0d)",
                     $time, data_o, want_data, want_tag);
        end
        errors += fails;
        if (want_tag >= 0 && want_tag < N_ENT) begin
            ent_slots[want_tag]++;
            ent_errors[want_tag] += fails;
            if (want_en) begin
                ent_hits[want_tag]++;
            end
        end

        en_i          = en;
        border_pass_i = border;
        for (int r = 0; r < WIN_N; r++) begin
            col_i.pix[r] = pixel_t'(col_v[r]);
        end

        // the window shifts on every edge, gap or not
        for (int c = WIN_N - 1; c > 0; c--) begin
            for (int r = 0; r < WIN_N; r++) begin
                win_m[c][r] = win_m[c-1][r];
            end
        end
        for (int r = 0; r < WIN_N; r++) begin
            win_m[0][r] = col_v[r];
        end
        run_len = en ? run_len + 1 : 0;
        want_en = en && (run_len >= WIN_N);
        exp_en_q.push_back(want_en);
        exp_data_q.push_back(want_en ? predict(border) : 0);
        exp_tag_q.push_back(tag);
    endtask

    task automatic run_entry(input int idx);
        entry_t e;
        int     col_v [WIN_N];
        e = tbl[idx];
        for (int c = 0; c < e.len; c++) begin
            for (int r = 0; r < WIN_N; r++) begin
                col_v[r] = gen_pixel(e.kind, e.base, r, c);
            end
            if (e.inj_r >= 0 && c == e.inj_c) begin
                col_v[e.inj_r] = e.inj_v;
            end
            step(1'b1, col_v, (c == e.border_c), idx);
        end
        for (int g = 0; g < e.gap; g++) begin
            for (int r = 0; r < WIN_N; r++) begin
                col_v[r] = 0;
            end
            step(1'b0, col_v, 1'b0, idx);
        end
    endtask

    initial begin
        int drain;
        int idle_v [WIN_N];
        clk           = 1'b0;
        rst_n         = 1'b0;
        en_i          = 1'b0;
        col_i         = '0;
        border_pass_i = 1'b0;
        run_len       = 0;
        checks        = 0;
        errors        = 0;
        report_idx    = -1;
        drain         = 0;
        for (int c = 0; c < WIN_N; c++) begin
            idle_v[c] = 0;
            for (int r = 0; r < WIN_N; r++) begin
                win_m[c][r] = 0;
            end
        end
        for (int i = 0; i < N_ENT; i++) begin
            ent_slots[i]  = 0;
            ent_hits[i]   = 0;
            ent_errors[i] = 0;
        end

        // len, kind, base, inj row, inj col, inj value, border col, gap
        tbl[0]  = '{3, K_FLAT, 2000, -1, 0, 0, -1, 1};       // too short for a window
        tbl[1]  = '{8, K_FLAT, 2000, -1, 0, 0, -1, 1};       // one-cycle gap before
        tbl[2]  = '{12, K_RAMP, 1000, -1, 0, 0, -1, 2};
        tbl[3]  = '{10, K_FLAT, 2048, 2, 5, PIX_MAX, -1, 3}; // salt replaced
        tbl[4]  = '{10, K_FLAT, 1800, 2, 4, 0, -1, 2};       // pepper replaced
        tbl[5]  = '{10, K_FLAT, 300, 2, 5, 0, -1, 2};        // small step kept
        tbl[6]  = '{10, K_FLAT, 680, 2, 5, 0, -1, 2};        // exactly at threshold
        tbl[7]  = '{10, K_FLAT, 681, 2, 5, 0, -1, 2};        // just above
        tbl[8]  = '{10, K_FLAT, 2048, 2, 5, PIX_MAX, 7, 2};  // centre col 5 on border
        tbl[9]  = '{10, K_RAMP, 1500, 1, 6, PIX_MAX, -1, 1};
        tbl[10] = '{40, K_RAND, 0, -1, 0, 0, -1, 2};
        tbl[11] = '{40, K_COARSE, 0, -1, 0, 0, -1, 1};
        tbl[12] = '{30, K_RAND, 0, -1, 0, 0, 12, 5};

        repeat (LAT) begin
            exp_en_q.push_back(1'b0);
            exp_data_q.push_back(0);
            exp_tag_q.push_back(-1);
        end

        repeat (5) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        for (int i = 0; i < N_ENT; i++) begin
            run_entry(i);
        end

        // idle until the last entry's slots are checked
        while (report_idx < N_ENT && drain < DRAIN_MAX) begin
            step(1'b0, idle_v, 1'b0, N_ENT);
            drain++;
        end
        if (report_idx < N_ENT) begin
            $display("timeout: slots of entry %0d still unchecked after %0d idle cycles",
                     report_idx, drain);
            errors++;
        end

        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* design/sp_noise_removal.sv */
`timescale 1ns/1ps
`default_nettype none

module sp_noise_removal
    import sp_pixel_pkg::*;
#(
    parameter int SIGMA = 160
) (
    input  logic    clk,
    input  logic    rst_n,
    input  logic    en_i,
    input  column_t col_i,
    input  logic    border_pass_i,
    output pixel_t  data_o,
    output logic    en_o
);

    logic                count_en;
    logic                clear;
    logic                full;
    logic                win_valid;
    logic                border_q;  // same stage as the window
    column_t [WIN_N-1:0] win;
    pixel_t              center;
    logic    [PIX_W:0]   grad_h;
    logic    [PIX_W:0]   grad_v;
    logic    [PIX_W:0]   grad_d;
    logic    [PIX_W:0]   grad_z;
    logic    [PIX_W:0]   intp_h;
    logic    [PIX_W:0]   intp_v;
    logic    [PIX_W:0]   intp_d;
    logic    [PIX_W:0]   intp_z;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            border_q <= 1'b0;
        end else begin
            border_q <= border_pass_i;
        end
    end

    column_counter i_column_counter (
        .clk        (clk),
        .rst_n      (rst_n),
        .count_en_i (count_en),
        .clear_i    (clear),
        .full_o     (full)
    );

    window_fsm i_window_fsm (
        .clk         (clk),
        .rst_n       (rst_n),
        .en_i        (en_i),
        .full_i      (full),
        .count_en_o  (count_en),
        .clear_o     (clear),
        .win_valid_o (win_valid)
    );

    window_buffer i_window_buffer (
        .clk      (clk),
        .rst_n    (rst_n),
        .col_i    (col_i),
        .win_o    (win),
        .center_o (center)
    );

    // two pipeline stages
    direction_calc i_direction_calc (
        .clk      (clk),
        .rst_n    (rst_n),
        .win_i    (win),
        .grad_h_o (grad_h),
        .grad_v_o (grad_v),
        .grad_d_o (grad_d),
        .grad_z_o (grad_z),
        .intp_h_o (intp_h),
        .intp_v_o (intp_v),
        .intp_d_o (intp_d),
        .intp_z_o (intp_z)
    );

    noise_decision #(
        .SIGMA (SIGMA)
    ) i_noise_decision (
        .clk         (clk),
        .rst_n       (rst_n),
        .grad_h_i    (grad_h),
        .grad_v_i    (grad_v),
        .grad_d_i    (grad_d),
        .grad_z_i    (grad_z),
        .intp_h_i    (intp_h),
        .intp_v_i    (intp_v),
        .intp_d_i    (intp_d),
        .intp_z_i    (intp_z),
        .center_i    (center),
        .border_i    (border_q),
        .win_valid_i (win_valid),
        .data_o      (data_o),
        .en_o        (en_o)
    );

endmodule

`default_nettype wire

/* design/noise_decision.sv */
`timescale 1ns/1ps
`default_nettype none

module noise_decision
    import sp_pixel_pkg::*;
    import sp_ctrl_pkg::*;
#(
    parameter int SIGMA = 160
) (
    input  logic           clk,
    input  logic           rst_n,
    input  logic [PIX_W:0] grad_h_i,
    input  logic [PIX_W:0] grad_v_i,
    input  logic [PIX_W:0] grad_d_i,
    input  logic [PIX_W:0] grad_z_i,
    input  logic [PIX_W:0] intp_h_i,
    input  logic [PIX_W:0] intp_v_i,
    input  logic [PIX_W:0] intp_d_i,
    input  logic [PIX_W:0] intp_z_i,
    input  pixel_t         center_i,
    input  logic           border_i,
    input  logic           win_valid_i,
    output pixel_t         data_o,
    output logic           en_o
);

    localparam int THRESH = (SIGMA * QUANT) >> QUANT_SHIFT;  // 680 at SIGMA 160
    localparam int DLY    = CALC_LAT - 1;                    // plus the output register

    logic [PIX_W:0] best_grad;
    logic [PIX_W:0] best_intp;
    pixel_t         clip;
    pixel_t         clip_q;
    pixel_t         center_d [DLY];
    logic [DLY-1:0] border_d;
    logic [DLY-1:0] valid_d;
    pixel_t         center_q;
    pixel_t         diff;
    logic           saturated;
    logic           replace;
    pixel_t         result;

    // strict compares keep the earlier direction on a tie
    always_comb begin
        best_grad = grad_h_i;
        best_intp = intp_h_i;
        if (grad_v_i < best_grad) begin
            best_grad = grad_v_i;
            best_intp = intp_v_i;
        end
        if (grad_d_i < best_grad) begin
            best_grad = grad_d_i;
            best_intp = intp_d_i;
        end
        if (grad_z_i < best_grad) begin
            best_grad = grad_z_i;
            best_intp = intp_z_i;
        end
    end

    assign clip = (best_intp > PIX_MAX) ? pixel_t'(PIX_MAX) : best_intp[PIX_W-1:0];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            clip_q   <= '0;
            border_d <= '0;
            valid_d  <= '0;
            for (int k = 0; k < DLY; k++) begin
                center_d[k] <= '0;
            end
        end else begin
            clip_q      <= clip;
            border_d    <= {border_d[DLY-2:0], border_i};
            valid_d     <= {valid_d[DLY-2:0], win_valid_i};
            center_d[0] <= center_i;
            for (int k = 1; k < DLY; k++) begin
                center_d[k] <= center_d[k-1];
            end
        end
    end

    // centre now lines up with clip_q
    assign center_q  = center_d[DLY-1];
    assign diff      = (center_q > clip_q) ? center_q - clip_q : clip_q - center_q;
    assign saturated = (center_q == '0) || (center_q == pixel_t'(PIX_MAX));
    assign replace   = !border_d[DLY-1] && saturated && (diff > THRESH);
    assign result    = replace ? clip_q : center_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            data_o <= '0;
            en_o   <= 1'b0;
        end else begin
            data_o <= valid_d[DLY-1] ? result : '0;  // quiet bus between results
            en_o   <= valid_d[DLY-1];
        end
    end

    // a clean centre comes out unchanged, CALC_LAT cycles after its window
    a_clean_pass: assert property (@(posedge clk) disable iff (!rst_n)
        win_valid_i && (center_i != '0) && (center_i != pixel_t'(PIX_MAX))
        |-> ##CALC_LAT (en_o && (data_o == $past(center_i, CALC_LAT))))
        else $error("clean centre changed or late, data_o %0d", data_o);

endmodule

`default_nettype wire

/* design/direction_calc.sv */
`timescale 1ns/1ps
`default_nettype none

module direction_calc
    import sp_pixel_pkg::*;
(
    input  logic                clk,
    input  logic                rst_n,
    input  column_t [WIN_N-1:0] win_i,
    output logic    [PIX_W:0]   grad_h_o,
    output logic    [PIX_W:0]   grad_v_o,
    output logic    [PIX_W:0]   grad_d_o,
    output logic    [PIX_W:0]   grad_z_o,
    output logic    [PIX_W:0]   intp_h_o,
    output logic    [PIX_W:0]   intp_v_o,
    output logic    [PIX_W:0]   intp_d_o,
    output logic    [PIX_W:0]   intp_z_o
);

    localparam int NDIR  = 4;
    localparam int DIR_H = 0;
    localparam int DIR_V = 1;
    localparam int DIR_D = 2;
    localparam int DIR_Z = 3;

    // tap pairs through the centre, outer at distance 2 and inner at 1
    pixel_t out_a [NDIR];
    pixel_t out_b [NDIR];
    pixel_t in_a  [NDIR];
    pixel_t in_b  [NDIR];

    // stage 1 pair terms
    pixel_t         dif_out_q [NDIR];
    pixel_t         dif_in_q  [NDIR];
    logic [PIX_W:0] avg_out_q [NDIR];
    logic [PIX_W:0] avg_in_q  [NDIR];

    // stage 2 sums
    logic [PIX_W:0] grad_q [NDIR];
    logic [PIX_W:0] intp_q [NDIR];

    function automatic pixel_t abs_diff(input pixel_t a, input pixel_t b);
        return (a > b) ? a - b : b - a;
    endfunction

    // (a + b + 1) / 2 without losing the carry
    function automatic logic [PIX_W:0] avg_rnd(input logic [PIX_W:0] a,
                                               input logic [PIX_W:0] b);
        logic [PIX_W+1:0] s;
        s = {1'b0, a} + {1'b0, b} + 1'b1;
        return s[PIX_W+1:1];
    endfunction

    // pixel (r, c) is win_i[c].pix[r]
    always_comb begin
        out_a[DIR_H] = win_i[0].pix[WIN_MID];  // centre row
        out_b[DIR_H] = win_i[4].pix[WIN_MID];
        in_a[DIR_H]  = win_i[1].pix[WIN_MID];
        in_b[DIR_H]  = win_i[3].pix[WIN_MID];

        out_a[DIR_V] = win_i[WIN_MID].pix[0];  // centre column
        out_b[DIR_V] = win_i[WIN_MID].pix[4];
        in_a[DIR_V]  = win_i[WIN_MID].pix[1];
        in_b[DIR_V]  = win_i[WIN_MID].pix[3];

        // 45 degrees, (0,0)/(4,4) and (1,1)/(3,3)
        out_a[DIR_D] = win_i[0].pix[0];
        out_b[DIR_D] = win_i[4].pix[4];
        in_a[DIR_D]  = win_i[1].pix[1];
        in_b[DIR_D]  = win_i[3].pix[3];

        // 135 degrees, (0,4)/(4,0) and (1,3)/(3,1)
        out_a[DIR_Z] = win_i[4].pix[0];
        out_b[DIR_Z] = win_i[0].pix[4];
        in_a[DIR_Z]  = win_i[3].pix[1];
        in_b[DIR_Z]  = win_i[1].pix[3];
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int d = 0; d < NDIR; d++) begin
                dif_out_q[d] <= '0;
                dif_in_q[d]  <= '0;
                avg_out_q[d] <= '0;
                avg_in_q[d]  <= '0;
                grad_q[d]    <= '0;
                intp_q[d]    <= '0;
            end
        end else begin
            for (int d = 0; d < NDIR; d++) begin
                dif_out_q[d] <= abs_diff(out_a[d], out_b[d]);
                dif_in_q[d]  <= abs_diff(in_a[d], in_b[d]);
                avg_out_q[d] <= avg_rnd({1'b0, out_a[d]}, {1'b0, out_b[d]});
                avg_in_q[d]  <= avg_rnd({1'b0, in_a[d]}, {1'b0, in_b[d]});
                grad_q[d]    <= {1'b0, dif_out_q[d]} + {1'b0, dif_in_q[d]};
                intp_q[d]    <= avg_rnd(avg_out_q[d], avg_in_q[d]);  // sum of both, halved
            end
        end
    end

    assign grad_h_o = grad_q[DIR_H];
    assign grad_v_o = grad_q[DIR_V];
    assign grad_d_o = grad_q[DIR_D];
    assign grad_z_o = grad_q[DIR_Z];
    assign intp_h_o = intp_q[DIR_H];
    assign intp_v_o = intp_q[DIR_V];
    assign intp_d_o = intp_q[DIR_D];
    assign intp_z_o = intp_q[DIR_Z];

endmodule

`default_nettype wire

/* design/window_buffer.sv */
`timescale 1ns/1ps
`default_nettype none

module window_buffer
    import sp_pixel_pkg::*;
(
    input  logic                clk,
    input  logic                rst_n,
    input  column_t             col_i,
    output column_t [WIN_N-1:0] win_o,
    output pixel_t              center_o
);

    // index 0 holds the newest column
    column_t [WIN_N-1:0] win_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int c = 0; c < WIN_N; c++) begin
                win_q[c].flat <= '0;
            end
        end else begin
            win_q[0] <= col_i;
            for (int c = 1; c < WIN_N; c++) begin
                win_q[c] <= win_q[c-1];  // oldest column drops out
            end
        end
    end

    assign win_o = win_q;

    // pixel (row WIN_MID, column WIN_MID)
    assign center_o = win_q[WIN_MID].pix[WIN_MID];

endmodule

`default_nettype wire

/* design/window_fsm.sv */
`timescale 1ns/1ps
`default_nettype none

module window_fsm
    import sp_pixel_pkg::*;
    import sp_ctrl_pkg::*;
(
    input  logic clk,
    input  logic rst_n,
    input  logic en_i,
    input  logic full_i,
    output logic count_en_o,
    output logic clear_o,
    output logic win_valid_o
);

    win_state_t state_q;
    win_state_t state_d;
    logic       valid_d;

    always_comb begin
        state_d = state_q;
        unique case (state_q)
            IDLE: begin
                if (en_i) begin
                    state_d = FILL;
                end
            end
            FILL: begin
                if (!en_i) begin
                    state_d = IDLE;
                end else if (full_i) begin
                    state_d = RUN;  // fifth column arriving
                end
            end
            RUN: begin
                if (!en_i) begin
                    state_d = IDLE;
                end
            end
            default: state_d = IDLE;
        endcase
    end

    // a result for every column that completes or extends a window
    assign valid_d = en_i && ((state_q == RUN) || ((state_q == FILL) && full_i));

    assign count_en_o = en_i;
    assign clear_o    = !en_i && (state_q != IDLE);  // one pulse per broken row

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q     <= IDLE;
            win_valid_o <= 1'b0;
        end else begin
            state_q     <= state_d;
            win_valid_o <= valid_d;
        end
    end

    // a gap means WIN_N fresh columns before the next window
    a_refill: assert property (@(posedge clk) disable iff (!rst_n)
        !en_i |=> !win_valid_o [*WIN_N])
        else $error("window valid during refill, state %s", state_q.name());

endmodule

`default_nettype wire

/* design/column_counter.sv */
`timescale 1ns/1ps
`default_nettype none

module column_counter
    import sp_pixel_pkg::*;
(
    input  logic clk,
    input  logic rst_n,
    input  logic count_en_i,
    input  logic clear_i,
    output logic full_o
);

    localparam int               CNT_W = $clog2(WIN_N);
    localparam logic [CNT_W-1:0] LAST  = CNT_W'(WIN_N - 1);

    logic [CNT_W-1:0] count_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            count_q <= '0;
        end else if (clear_i) begin
            count_q <= '0;  // row broken, start over
        end else if (count_en_i && (count_q != LAST)) begin
            count_q <= count_q + 1'b1;
        end
    end

    // next counted column closes a window
    assign full_o = (count_q == LAST);

    // a broken row needs WIN_N-1 fresh columns before the window can close
    a_refill_count: assert property (@(posedge clk) disable iff (!rst_n)
        clear_i |=> !full_o [*(WIN_N-1)])
        else $error("full_o within %0d columns of a clear", WIN_N - 1);

endmodule

`default_nettype wire

/* design/sp_ctrl_pkg.sv */
`default_nettype none

package sp_ctrl_pkg;

    // row fill states
    typedef enum logic [1:0] {
        IDLE = 2'd0,  // no column on the bus
        FILL = 2'd1,  // first columns of a row
        RUN  = 2'd2   // window complete, one result per column
    } win_state_t;

    // window register to output register
    localparam int CALC_LAT = 4;

    // sampled column to data_o, includes the window register
    localparam int TOP_LAT = CALC_LAT + 1;

endpackage

`default_nettype wire

/* design/sp_pixel_pkg.sv */
`default_nettype none

package sp_pixel_pkg;

    // pixel geometry
    localparam int PIX_W   = 12;
    localparam int PIX_MAX = (1 << PIX_W) - 1;  // saturated white, 4095

    // window geometry, taps in direction_calc assume 5x5
    localparam int WIN_N   = 5;
    localparam int WIN_MID = WIN_N / 2;  // centre row and column

    typedef logic [PIX_W-1:0] pixel_t;

    // one incoming column, row 0 sits in the top bits of the flat word
    typedef union packed {
        logic [WIN_N*PIX_W-1:0] flat;
        pixel_t [0:WIN_N-1]     pix;
    } column_t;

    // noise threshold is SIGMA * QUANT / 16
    localparam int QUANT       = 68;
    localparam int QUANT_SHIFT = 4;

endpackage

`default_nettype wire
